// ==== compile.f ====
hdl/rvseed_isa_pkg.sv
hdl/rvseed_core_pkg.sv
hdl/dmem_if.sv
hdl/pipe_stage.sv
hdl/reg_file.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/data_ram.sv
hdl/rv64_exec_core.sv
sim/rv64_exec_core_chk.sv
sim/rv64_exec_core_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  rvseed_isa_pkg::alu_op_e          alu_op,
    input  logic [rvseed_core_pkg::XLEN-1:0] src1,
    input  logic [rvseed_core_pkg::XLEN-1:0] src2,
    output logic [rvseed_core_pkg::XLEN-1:0] res
);

    import rvseed_isa_pkg::*;
    import rvseed_core_pkg::*;

    logic signed [31:0] a_w;
    logic signed [31:0] b_w;
    logic        [31:0] word_res;
    logic               div_ovf;
    logic        [5:0]  shamt;

    assign a_w     = src1[31:0];
    assign b_w     = src2[31:0];
    assign shamt   = src2[5:0];
    assign div_ovf = (a_w == 32'sh8000_0000) && (b_w == -32'sd1);

    always_comb begin
        case (alu_op)
            ALU_DIVW: begin
                if (b_w == 32'sd0) begin
                    word_res = '1;
                end else if (div_ovf) begin
                    word_res = a_w;
                end else begin
                    word_res = a_w / b_w;
                end
            end
            ALU_REMW: begin
                if (b_w == 32'sd0) begin
                    word_res = a_w;
                end else if (div_ovf) begin
                    word_res = '0;
                end else begin
                    word_res = a_w % b_w;
                end
            end
            default: word_res = a_w + b_w; // addw
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:    res = src1 + src2;
            ALU_SUB:    res = src1 - src2;
            ALU_AND:    res = src1 & src2;
            ALU_OR:     res = src1 | src2;
            ALU_XOR:    res = src1 ^ src2;
            ALU_SLL:    res = src1 << shamt;
            ALU_SRA:    res = $signed(src1) >>> shamt;
            ALU_SLTU:   res = {{(XLEN-1){1'b0}}, src1 < src2};
            ALU_MUL:    res = src1 * src2; // low half
            ALU_ADDW,
            ALU_DIVW,
            ALU_REMW:   res = {{32{word_res[31]}}, word_res};
            ALU_PASS_B: res = src2;
            default:    res = '0;
        endcase
    end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/1ns

module data_ram (
    input  logic   clk,
    input  logic   arst_n,
    dmem_if.memory dmem
);

    import rvseed_core_pkg::*;

    logic [XLEN-1:0]        mem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] idx;
    logic                   store;
    logic                   busy; // cycle after a store

    assign idx            = dmem.addr[DMEM_ADDR_W+2:3]; // doubleword index
    assign dmem.req_ready = !busy;
    assign dmem.rdata     = mem[idx];
    assign store          = dmem.req_valid && dmem.req_ready && dmem.write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else begin
            busy <= store;
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            mem[idx] <= dmem.wdata;
        end
    end

endmodule

// ==== hdl/dmem_if.sv ====
`timescale 1ns/1ns

interface dmem_if;

    import rvseed_core_pkg::*;

    logic            req_valid;
    logic            req_ready;
    logic            write;
    logic [XLEN-1:0] addr;  // byte address
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata; // same cycle as request

    modport requester (output req_valid, write, addr, wdata, input req_ready, rdata);
    modport memory (input req_valid, write, addr, wdata, output req_ready, rdata);

endinterface

// ==== hdl/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit (
    input  logic                      in_valid,
    output logic                      in_ready,
    input  rvseed_core_pkg::exe_req_t in_req,
    output logic                      out_valid,
    input  logic                      out_ready,
    output rvseed_core_pkg::wb_t      out_wb,
    dmem_if.requester                 dmem
);

    import rvseed_isa_pkg::*;
    import rvseed_core_pkg::*;

    logic [XLEN-1:0] alu_res;
    logic            is_mem;
    logic            mem_ok;
    logic [31:0]     word_sel;
    logic [7:0]      byte_sel;

    alu alu_i (
        .alu_op (in_req.alu_op),
        .src1   (in_req.op_a),
        .src2   (in_req.op_b),
        .res    (alu_res)
    );

    assign is_mem = (in_req.mem_op != MEM_NONE);
    assign mem_ok = !is_mem || dmem.req_ready;

    // join of pipeline and RAM handshakes
    assign in_ready       = out_ready && mem_ok;
    assign out_valid      = in_valid && mem_ok;
    assign dmem.req_valid = in_valid && is_mem && out_ready;
    assign dmem.write     = (in_req.mem_op == MEM_SD);
    assign dmem.addr      = alu_res;
    assign dmem.wdata     = in_req.store_data;

    assign word_sel = alu_res[2] ? dmem.rdata[63:32] : dmem.rdata[31:0];
    assign byte_sel = dmem.rdata[{alu_res[2:0], 3'b000} +: 8];

    always_comb begin
        out_wb.rd = in_req.rd;
        case (in_req.mem_op)
            MEM_LD:  out_wb.data = dmem.rdata;
            MEM_LW:  out_wb.data = {{32{word_sel[31]}}, word_sel};
            MEM_LBU: out_wb.data = {56'b0, byte_sel};
            MEM_SD: begin
                out_wb.rd   = '0;
                out_wb.data = '0;
            end
            default: out_wb.data = alu_res;
        endcase
    end

endmodule

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ns

module instr_decoder (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  instr_valid,
    output logic                                  instr_ready,
    input  logic [31:0]                           instr,
    output logic [rvseed_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rvseed_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rvseed_core_pkg::XLEN-1:0]       rs1_data,
    input  logic [rvseed_core_pkg::XLEN-1:0]       rs2_data,
    output logic                                  req_valid,
    input  logic                                  req_ready,
    output rvseed_core_pkg::exe_req_t              req,
    input  logic                                  retire_valid,
    input  logic [rvseed_core_pkg::REG_ADDR_W-1:0] retire_rd
);

    import rvseed_isa_pkg::*;
    import rvseed_core_pkg::*;

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [XLEN-1:0]     imm_i;
    logic [XLEN-1:0]     imm_s;
    logic [XLEN-1:0]     imm_u;
    logic                use_rs1;
    logic                use_rs2;
    logic                has_rd;
    logic                legal;
    logic                hazard;
    logic                run;      // low through reset
    logic [NUM_REGS-1:0] busy;
    logic [NUM_REGS-1:0] clear_vec;
    logic [NUM_REGS-1:0] pend;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign imm_i    = {{52{instr[31]}}, instr[31:20]};
    assign imm_s    = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u    = {{32{instr[31]}}, instr[31:12], 12'b0};

    always_comb begin
        req.alu_op     = ALU_ADD;
        req.mem_op     = MEM_NONE;
        req.op_a       = rs1_data;
        req.op_b       = rs2_data;
        req.store_data = rs2_data;
        use_rs1        = 1'b1;
        use_rs2        = 1'b0;
        has_rd         = 1'b1;
        legal          = 1'b1;
        case (opcode)
            OPC_OP: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:    req.alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:     req.alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}:    req.alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:     req.alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}:    req.alu_op = ALU_XOR;
                    {F7_BASE, F3_SLL}:    req.alu_op = ALU_SLL;
                    {F7_ALT, F3_SRA}:     req.alu_op = ALU_SRA;
                    {F7_BASE, F3_SLTU}:   req.alu_op = ALU_SLTU;
                    {F7_MULDIV, F3_MUL}:  req.alu_op = ALU_MUL;
                    default:              legal = 1'b0;
                endcase
            end
            OPC_OP_32: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:    req.alu_op = ALU_ADDW;
                    {F7_MULDIV, F3_DIVW}: req.alu_op = ALU_DIVW;
                    {F7_MULDIV, F3_REMW}: req.alu_op = ALU_REMW;
                    default:              legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                req.op_b = imm_i;
                legal    = (funct3 == F3_ADD); // addi only
            end
            OPC_LUI: begin
                use_rs1    = 1'b0;
                req.alu_op = ALU_PASS_B;
                req.op_b   = imm_u;
            end
            OPC_LOAD: begin
                req.op_b = imm_i;
                case (funct3)
                    F3_LD:   req.mem_op = MEM_LD;
                    F3_LW:   req.mem_op = MEM_LW;
                    F3_LBU:  req.mem_op = MEM_LBU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_STORE: begin
                use_rs2    = 1'b1;
                has_rd     = 1'b0;
                req.op_b   = imm_s;
                req.mem_op = MEM_SD;
                legal      = (funct3 == F3_SD);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin // retire as a no-op with rd 0 and data 0
            use_rs1    = 1'b0;
            use_rs2    = 1'b0;
            has_rd     = 1'b0;
            req.alu_op = ALU_PASS_B;
            req.mem_op = MEM_NONE;
            req.op_b   = '0;
        end
        req.rd = has_rd ? instr[11:7] : '0;
    end

    // a bit freed this cycle is no hazard
    assign clear_vec = retire_valid ? (NUM_REGS'(1) << retire_rd) : '0;
    assign pend      = busy & ~clear_vec;
    assign hazard    = (use_rs1 && pend[rs1_addr]) || (use_rs2 && pend[rs2_addr]) ||
                       pend[req.rd];

    assign req_valid   = instr_valid && run && !hazard;
    assign instr_ready = run && req_ready && !hazard;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run  <= 1'b0;
            busy <= '0;
        end else begin
            run <= 1'b1;
            if (retire_valid) begin
                busy[retire_rd] <= 1'b0;
            end
            if (req_valid && req_ready && req.rd != '0) begin
                busy[req.rd] <= 1'b1; // wins over a same-cycle clear
            end
        end
    end

endmodule

// ==== hdl/pipe_stage.sv ====
`timescale 1ns/1ns

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    assign in_ready = !out_valid || out_ready; // empty or draining

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [rvseed_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rvseed_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rvseed_core_pkg::XLEN-1:0]       rs1_data,
    output logic [rvseed_core_pkg::XLEN-1:0]       rs2_data,
    input  logic                                  wr_en,
    input  logic [rvseed_core_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [rvseed_core_pkg::XLEN-1:0]       wr_data
);

    import rvseed_core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // write-first bypass
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

// ==== hdl/rv64_exec_core.sv ====
`timescale 1ns/1ns

module rv64_exec_core (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  instr_valid,
    output logic                                  instr_ready,
    input  logic [31:0]                           instr,
    output logic                                  wb_valid,
    input  logic                                  wb_ready,
    output logic [rvseed_core_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [rvseed_core_pkg::XLEN-1:0]       wb_data
);

    import rvseed_core_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  dec_valid;
    logic                  dec_ready;
    exe_req_t              dec_req;
    logic                  exe_valid;
    logic                  exe_ready;
    exe_req_t              exe_req;
    logic                  res_valid;
    logic                  res_ready;
    wb_t                   res_wb;
    wb_t                   wb_q;
    logic                  retire;

    dmem_if dmem ();

    assign wb_rd   = wb_q.rd;
    assign wb_data = wb_q.data;
    assign retire  = wb_valid && wb_ready;

    instr_decoder decoder_i (
        .clk, .arst_n, .instr_valid, .instr_ready, .instr,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .req_valid (dec_valid), .req_ready (dec_ready), .req (dec_req),
        .retire_valid (retire), .retire_rd (wb_q.rd)
    );

    reg_file reg_file_i (
        .clk, .arst_n, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .wr_en (retire), .wr_addr (wb_q.rd), .wr_data (wb_q.data)
    );

    pipe_stage #(.payload_t(exe_req_t)) d2e_i (
        .clk, .arst_n,
        .in_valid (dec_valid), .in_ready (dec_ready), .in_data (dec_req),
        .out_valid (exe_valid), .out_ready (exe_ready), .out_data (exe_req)
    );

    exec_unit exec_i (
        .in_valid (exe_valid), .in_ready (exe_ready), .in_req (exe_req),
        .out_valid (res_valid), .out_ready (res_ready), .out_wb (res_wb),
        .dmem (dmem.requester)
    );

    pipe_stage #(.payload_t(wb_t)) e2w_i (
        .clk, .arst_n,
        .in_valid (res_valid), .in_ready (res_ready), .in_data (res_wb),
        .out_valid (wb_valid), .out_ready (wb_ready), .out_data (wb_q)
    );

    data_ram ram_i (
        .clk, .arst_n, .dmem (dmem.memory)
    );

endmodule

// ==== hdl/rvseed_core_pkg.sv ====
package rvseed_core_pkg;

    import rvseed_isa_pkg::*;

    localparam int XLEN        = 64;
    localparam int NUM_REGS    = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 512;
    localparam int DMEM_ADDR_W = 9; // byte address wraps at 4 KiB

    // decoded instruction with the immediate already in op_b
    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       store_data;
    } exe_req_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

// ==== hdl/rvseed_isa_pkg.sv ====
package rvseed_isa_pkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_32  = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD  = 3'b000; // also addi, addw, sub
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRA  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_MUL  = 3'b000;
    localparam logic [2:0] F3_DIVW = 3'b100;
    localparam logic [2:0] F3_REMW = 3'b110;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LD   = 3'b011;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_SD   = 3'b011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDW,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRA,
        ALU_SLTU,
        ALU_MUL,
        ALU_DIVW,
        ALU_REMW,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LD,
        MEM_LW,
        MEM_LBU,
        MEM_SD
    } mem_op_e;

endpackage

// ==== sim/rv64_exec_core_chk.sv ====
`timescale 1ns/1ns

module rv64_exec_core_chk (
    input logic                                  clk,
    input logic                                  arst_n,
    input logic                                  instr_valid,
    input logic                                  instr_ready,
    input logic                                  wb_valid,
    input logic                                  wb_ready,
    input logic [rvseed_core_pkg::REG_ADDR_W-1:0] wb_rd,
    input logic [rvseed_core_pkg::XLEN-1:0]       wb_data
);

    import rvseed_core_pkg::*;

    logic [NUM_REGS-1:0] written; // rds retired since the last accepted instruction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            written <= '0;
        end else if (instr_valid && instr_ready) begin
            written <= '0;
        end else if (wb_valid && wb_ready && wb_rd != '0) begin
            written <= written | (NUM_REGS'(1) << wb_rd);
        end
    end

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !wb_valid && !instr_ready)
        else $error("wb_valid or instr_ready high during reset");

    wb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_rd) && $stable(wb_data))
        else $error("writeback changed while stalled");

    no_double_wb: assert property (@(posedge clk) disable iff (!arst_n)
        wb_valid && wb_ready && wb_rd != '0 |-> !written[wb_rd])
        else $error("second writeback to x%0d without a new instruction", wb_rd);

endmodule

// ==== sim/rv64_exec_core_tb.sv ====
`timescale 1ns/1ns

module rv64_exec_core_tb;

    import rvseed_isa_pkg::*;
    import rvseed_core_pkg::*;

    logic                  clk;
    logic                  arst_n;
    logic                  instr_valid;
    logic                  instr_ready;
    logic [31:0]           instr;
    logic                  wb_valid;
    logic                  wb_ready;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    logic [XLEN-1:0] xreg [NUM_REGS];  // model state
    logic [XLEN-1:0] ram_model [DMEM_WORDS];
    logic [31:0]     prog [$];
    wb_t             exp_q [$];
    bit              ready_pat [256];
    int              errors;
    int              checks;
    int              wb_count;
    int              cycles;
    int              limit;

    rv64_exec_core dut_i (
        .clk, .arst_n, .instr_valid, .instr_ready, .instr,
        .wb_valid, .wb_ready, .wb_rd, .wb_data
    );

    bind rv64_exec_core rv64_exec_core_chk chk_i (
        .clk, .arst_n, .instr_valid, .instr_ready, .wb_valid, .wb_ready, .wb_rd, .wb_data
    );

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, F3_SD, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // ISA reference that updates xreg and ram_model in program order
    function automatic wb_t ref_exec(input logic [31:0] w);
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    sum;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    saddr;
        logic [XLEN-1:0]    dword;
        logic signed [63:0] na;
        logic signed [63:0] nb;
        logic [63:0]        quo;
        logic [63:0]        rem;
        wb_t                e;
        a      = xreg[w[19:15]];
        b      = xreg[w[24:20]];
        sum    = a + b;
        na     = {{32{a[31]}}, a[31:0]};
        nb     = {{32{b[31]}}, b[31:0]};
        if (nb == 0) begin
            quo = '1;
            rem = na;
        end else begin
            quo = na / nb; // -2^31 / -1 wraps to the dividend
            rem = na % nb;
        end
        addr   = a + {{52{w[31]}}, w[31:20]};
        saddr  = a + {{52{w[31]}}, w[31:25], w[11:7]};
        e.rd   = w[11:7];
        e.data = '0;
        case (w[6:0])
            OPC_OP: begin
                case ({w[31:25], w[14:12]})
                    {F7_BASE, F3_ADD}:  e.data = sum;
                    {F7_ALT, F3_ADD}:   e.data = a - b;
                    {F7_BASE, F3_AND}:  e.data = a & b;
                    {F7_BASE, F3_OR}:   e.data = a | b;
                    {F7_BASE, F3_XOR}:  e.data = a ^ b;
                    {F7_BASE, F3_SLL}:  e.data = a << b[5:0];
                    {F7_ALT, F3_SRA}:   e.data = $signed(a) >>> b[5:0];
                    {F7_BASE, F3_SLTU}: e.data = {63'd0, a < b};
                    default:            e.data = a * b; // mul
                endcase
            end
            OPC_OP_32: begin
                case (w[14:12])
                    F3_DIVW: e.data = {{32{quo[31]}}, quo[31:0]};
                    F3_REMW: e.data = {{32{rem[31]}}, rem[31:0]};
                    default: e.data = {{32{sum[31]}}, sum[31:0]};
                endcase
            end
            OPC_OP_IMM: e.data = addr; // addi
            OPC_LUI:    e.data = {{32{w[31]}}, w[31:12], 12'h000};
            OPC_LOAD: begin
                dword = ram_model[addr[11:3]];
                case (w[14:12])
                    F3_LD:   e.data = dword;
                    F3_LW: begin
                        if (addr[2]) begin
                            e.data = {{32{dword[63]}}, dword[63:32]};
                        end else begin
                            e.data = {{32{dword[31]}}, dword[31:0]};
                        end
                    end
                    default: e.data = {56'd0, dword[8*addr[2:0] +: 8]};
                endcase
            end
            OPC_STORE: begin
                ram_model[saddr[11:3]] = b;
                e.rd = '0;
            end
            default: e.rd = '0;
        endcase
        if (e.rd != '0) begin
            xreg[e.rd] = e.data;
        end
        return e;
    endfunction

    task automatic build_program();
        logic [16:0] alu_ops [12];
        logic [9:0]  pairs [4];
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] off;
        int          sel;
        int          k;
        alu_ops = '{{F7_BASE, F3_ADD, OPC_OP}, {F7_ALT, F3_ADD, OPC_OP},
                    {F7_BASE, F3_AND, OPC_OP}, {F7_BASE, F3_OR, OPC_OP},
                    {F7_BASE, F3_XOR, OPC_OP}, {F7_BASE, F3_SLL, OPC_OP},
                    {F7_ALT, F3_SRA, OPC_OP}, {F7_BASE, F3_SLTU, OPC_OP},
                    {F7_MULDIV, F3_MUL, OPC_OP}, {F7_BASE, F3_ADD, OPC_OP_32},
                    {F7_MULDIV, F3_DIVW, OPC_OP_32}, {F7_MULDIV, F3_REMW, OPC_OP_32}};
        pairs = '{{5'd1, 5'd2}, {5'd3, 5'd4}, {5'd3, 5'd6}, {5'd1, 5'd0}}; // {rs1, rs2}
        prog.push_back(r_word(F7_BASE, 5'd3, 5'd2, F3_ADD, 5'd1, OPC_OP)); // regs start at zero
        prog.push_back(r_word(F7_BASE, 5'd31, 5'd0, F3_OR, 5'd4, OPC_OP));
        prog.push_back(i_word(12'hffb, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM)); // -5
        prog.push_back(i_word(12'h123, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM)); // shamt 35
        prog.push_back(u_word(20'h80000, 5'd3));
        prog.push_back(u_word(20'h7ffff, 5'd4));
        prog.push_back(i_word(12'h7ff, 5'd4, F3_ADD, 5'd4, OPC_OP_IMM)); // shamt 63
        prog.push_back(i_word(12'hfff, 5'd0, F3_ADD, 5'd6, OPC_OP_IMM));
        k = 0;
        foreach (pairs[p]) begin
            foreach (alu_ops[i]) begin
                prog.push_back(r_word(alu_ops[i][16:10], pairs[p][4:0], pairs[p][9:5],
                                      alu_ops[i][9:7], 5'(7 + k % 25), alu_ops[i][6:0]));
                k++;
            end
        end
        prog.push_back(s_word(12'd0, 5'd3, 5'd0));
        prog.push_back(s_word(12'd8, 5'd1, 5'd0));
        prog.push_back(i_word(12'd0, 5'd0, F3_LD, 5'd7, OPC_LOAD));
        prog.push_back(i_word(12'd4, 5'd0, F3_LW, 5'd8, OPC_LOAD));
        prog.push_back(i_word(12'd0, 5'd0, F3_LW, 5'd9, OPC_LOAD));
        prog.push_back(i_word(12'd3, 5'd0, F3_LBU, 5'd10, OPC_LOAD));
        prog.push_back(i_word(12'd9, 5'd0, F3_LBU, 5'd11, OPC_LOAD));
        prog.push_back(u_word(20'h00001, 5'd12)); // base 4096 wraps to 0
        prog.push_back(s_word(12'd16, 5'd4, 5'd12));
        prog.push_back(i_word(12'd16, 5'd0, F3_LD, 5'd13, OPC_LOAD));
        prog.push_back(r_word(F7_BASE, 5'd13, 5'd13, F3_ADD, 5'd14, OPC_OP));
        prog.push_back(r_word(F7_BASE, 5'd13, 5'd14, F3_ADD, 5'd14, OPC_OP));
        prog.push_back(r_word(F7_BASE, 5'd14, 5'd14, F3_ADD, 5'd15, OPC_OP));
        prog.push_back(i_word(12'd8, 5'd0, F3_LD, 5'd16, OPC_LOAD));
        prog.push_back(r_word(F7_BASE, 5'd16, 5'd16, F3_ADD, 5'd17, OPC_OP)); // load use
        prog.push_back(i_word(12'd5, 5'd1, F3_ADD, 5'd0, OPC_OP_IMM));
        prog.push_back(r_word(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd18, OPC_OP));
        for (int i = 0; i < 16; i++) begin
            prog.push_back(s_word(12'(8 * i), 5'(7 + i), 5'd0)); // fill bytes 0..127
        end
        for (int n = 0; n < 230; n++) begin
            sel = $urandom % 18;
            rd  = 5'($urandom);
            rs1 = 5'($urandom);
            rs2 = 5'($urandom);
            off = 12'($urandom % 128);
            case (sel)
                12:      prog.push_back(i_word(12'($urandom), rs1, F3_ADD, rd, OPC_OP_IMM));
                13:      prog.push_back(u_word(20'($urandom), rd));
                14:      prog.push_back(i_word(off, 5'd0, F3_LD, rd, OPC_LOAD));
                15:      prog.push_back(i_word(off, 5'd0, F3_LW, rd, OPC_LOAD));
                16:      prog.push_back(i_word(off, 5'd0, F3_LBU, rd, OPC_LOAD));
                17:      prog.push_back(s_word(off, rs2, 5'd0));
                default: prog.push_back(r_word(alu_ops[sel][16:10], rs2, rs1,
                                               alu_ops[sel][9:7], rd, alu_ops[sel][6:0]));
            endcase
        end
    endtask

    task automatic issue(input logic [31:0] word);
        logic taken;
        instr_valid = 1'b1;
        instr       = word;
        do begin
            @(negedge clk);
            taken = instr_ready;
            @(posedge clk);
            #1;
        end while (!taken);
    endtask

    task automatic report_counts();
        $display("checks %0d, errors %0d, writebacks %0d of %0d",
                 checks, errors, wb_count, prog.size());
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        wb_ready = ready_pat[cycles % 256]; // about one idle cycle in four
    end

    always @(posedge clk) begin
        cycles++;
    end

    initial begin
        wait (cycles > limit);
        $display("timeout after %0d cycles waiting for writebacks", cycles);
        report_counts();
        $display("Simulation failed");
        $finish;
    end

    always @(negedge clk) begin
        wb_t want;
        if (arst_n && wb_valid && wb_ready) begin
            wb_count++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("writeback at %0t with no instruction outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                want = exp_q.pop_front();
                checks++;
                assert (wb_rd == want.rd && wb_data == want.data) else begin
                    errors++;
                    $display("FAIL %0t: writeback %0d got x%0d = %h, expected x%0d = %h",
                             $time, wb_count, wb_rd, wb_data, want.rd, want.data);
                end
            end
        end
    end

    initial begin
        void'($urandom(11811));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        wb_ready    = 1'b0;
        errors      = 0;
        checks      = 0;
        wb_count    = 0;
        cycles      = 0;
        foreach (ready_pat[i]) begin
            ready_pat[i] = ($urandom % 4) != 0;
        end
        foreach (xreg[i]) begin
            xreg[i] = '0;
        end
        build_program();
        foreach (prog[i]) begin
            exp_q.push_back(ref_exec(prog[i]));
        end
        limit = 8 * prog.size() + 200;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        foreach (prog[i]) begin
            issue(prog[i]);
        end
        instr_valid = 1'b0;
        wait (wb_count == prog.size());
        repeat (10) @(posedge clk); // catch duplicates
        assert (wb_count == prog.size() && exp_q.size() == 0) else begin
            errors++;
            $display("%0d writebacks seen for %0d instructions sent", wb_count, prog.size());
        end
        report_counts();
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
